//--- Makefile
# Verilator build and run of the UART testbench
TOP = uart_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check for a pass"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f uart_top.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test OK"

clean:
	rm -rf obj_dir

//--- hdl/baud_tick_gen.sv
/* Baud tick generator, one tick every divisor+1 clocks */

`timescale 1ns/1ps
`include "uart_defines.svh"

module baud_tick_gen(
	input logic clk,
	input logic reset,
	input uart_pkg::uart_divisor_t divisor,
	input logic divisor_load,
	output logic tick
);
	uart_pkg::uart_divisor_t count;

	// Tick in the cycle the count reaches zero
	assign tick = count == '0;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			count <= uart_pkg::uart_divisor_t'(`UART_RESET_DIVISOR);
		else if (divisor_load)
		begin
			// New rate starts from a full period
			count <= divisor;
		end
		else if (count == '0)
			count <= divisor;
		else
			count <= count - 1'b1;
	end
endmodule

//--- hdl/synchronizer.sv
/* Two-flop synchronizer, brings an asynchronous input into the clock domain */

`timescale 1ns/1ps

module synchronizer #(
	parameter logic RESET_STATE = 1'b0
)(
	input logic clk,
	input logic reset,
	input logic data_in,
	output logic data_out
);
	// First stage may go metastable
	logic stage1;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			stage1 <= RESET_STATE;
			data_out <= RESET_STATE;
		end
		else
		begin
			stage1 <= data_in;
			data_out <= stage1;
		end
	end
endmodule

//--- hdl/uart_defines.svh
/* UART widths, FIFO depth, reset divisor, register offsets and status bit numbers */

`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Character and divisor widths
`define UART_DATA_WIDTH 8
`define UART_DIV_WIDTH 16
`define UART_RESET_DIVISOR 3
`define UART_RX_FIFO_DEPTH 8

// Receiver oversampling
`define UART_TICKS_PER_BIT 8
`define UART_START_TICKS 12

// Word offsets on the bus
`define UART_REG_DATA 0
`define UART_REG_STATUS 1
`define UART_REG_DIVISOR 2

// Status register bits
`define UART_STATUS_RX_AVAIL 0
`define UART_STATUS_TX_BUSY 1
`define UART_STATUS_RX_OVERFLOW 2

`endif

//--- hdl/uart_pkg.sv
/* Serial-side types of the UART: characters, divisor, counts and FSM states */

`include "uart_defines.svh"

package uart_pkg;
	// One character on the line
	typedef logic [`UART_DATA_WIDTH-1:0] uart_char_t;

	// Baud divisor, one tick every divisor+1 clocks
	typedef logic [`UART_DIV_WIDTH-1:0] uart_divisor_t;

	// Ticks within a bit, must hold the start offset of 12
	typedef logic [3:0] uart_tick_count_t;

	// Bits within a frame
	typedef logic [3:0] uart_bit_count_t;

	typedef enum logic [0:0] {
		WAIT_START,
		READ_CHARACTER
	} receive_state_t;

	typedef enum logic [1:0] {
		IDLE,
		START_BIT,
		DATA_BITS,
		STOP_BIT
	} transmit_state_t;
endpackage

//--- hdl/uart_receive.sv
/* UART receiver FSM, hunts for the start bit and samples 8 data bits mid-bit */

`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_receive(
	input logic clk,
	input logic reset,
	input logic rx_sync,
	input logic tick,
	output uart_pkg::uart_char_t rx_char,
	output logic rx_char_valid
);
	localparam uart_pkg::uart_tick_count_t START_TICKS = `UART_START_TICKS;
	localparam uart_pkg::uart_tick_count_t BIT_TICKS = `UART_TICKS_PER_BIT;
	localparam uart_pkg::uart_bit_count_t STOP_INDEX = `UART_DATA_WIDTH;

	uart_pkg::receive_state_t state_ff;
	uart_pkg::receive_state_t state_nxt;
	uart_pkg::uart_tick_count_t sample_count_ff;
	uart_pkg::uart_tick_count_t sample_count_nxt;
	uart_pkg::uart_bit_count_t bit_count_ff;
	uart_pkg::uart_bit_count_t bit_count_nxt;
	uart_pkg::uart_char_t shift_reg;
	logic do_shift;

	assign rx_char = shift_reg;

	always_comb
	begin
		state_nxt = state_ff;
		sample_count_nxt = sample_count_ff;
		bit_count_nxt = bit_count_ff;
		rx_char_valid = 1'b0;
		do_shift = 1'b0;

		unique case (state_ff)
			uart_pkg::WAIT_START:
			begin
				// First low sample begins a frame
				if (!rx_sync)
				begin
					state_nxt = uart_pkg::READ_CHARACTER;
					// One and a half bits to the middle of bit 0
					sample_count_nxt = START_TICKS;
				end
			end

			uart_pkg::READ_CHARACTER:
			begin
				if (sample_count_ff == '0)
				begin
					sample_count_nxt = BIT_TICKS;
					if (bit_count_ff == STOP_INDEX)
					begin
						// Stop bit point, character complete
						state_nxt = uart_pkg::WAIT_START;
						rx_char_valid = 1'b1;
						bit_count_nxt = '0;
					end
					else
					begin
						do_shift = 1'b1;
						bit_count_nxt = bit_count_ff + 1'b1;
					end
				end
				else if (tick)
					sample_count_nxt = sample_count_ff - 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= uart_pkg::WAIT_START;
			sample_count_ff <= '0;
			bit_count_ff <= '0;
		end
		else
		begin
			state_ff <= state_nxt;
			sample_count_ff <= sample_count_nxt;
			bit_count_ff <= bit_count_nxt;
		end
	end

	// Data arrives LSB first, so shift in from the top
	always_ff @(posedge clk)
	begin
		if (do_shift)
			shift_reg <= {rx_sync, shift_reg[`UART_DATA_WIDTH-1:1]};
	end
endmodule

//--- hdl/uart_rx_fifo.sv
/* Circular receive FIFO, drops pushes when full and keeps a sticky overflow flag */

`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_rx_fifo(
	input logic clk,
	input logic reset,
	input logic push,
	input uart_pkg::uart_char_t push_data,
	input logic pop,
	output uart_pkg::uart_char_t pop_data,
	output logic empty,
	output logic overflow,
	input logic overflow_clear
);
	localparam int DEPTH = `UART_RX_FIFO_DEPTH;
	localparam int PTR_WIDTH = $clog2(DEPTH);

	uart_pkg::uart_char_t storage [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	// One bit wider than the pointers to tell full from empty
	logic [PTR_WIDTH:0] count;
	logic full;
	logic do_push;
	logic do_pop;

	assign empty = count == '0;
	assign full = count == (PTR_WIDTH + 1)'(DEPTH);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;
	// Oldest entry always visible
	assign pop_data = storage[rd_ptr];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			// Power-of-two depth, pointers wrap by themselves
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;

			// A drop in the clear cycle still sets the flag
			if (push && full)
				overflow <= 1'b1;
			else if (overflow_clear)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			storage[wr_ptr] <= push_data;
	end
endmodule

//--- hdl/uart_top.sv
/* UART peripheral top, serial receiver and transmitter behind a Wishbone slave */

`timescale 1ns/1ps

module uart_top(
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_pkg::wb_addr_t wb_adr,
	input wb_pkg::wb_data_t wb_dat_w,
	output wb_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	input logic uart_rx,
	output logic uart_tx
);
	logic rx_sync;
	logic tick;
	uart_pkg::uart_divisor_t divisor;
	logic divisor_load;
	uart_pkg::uart_char_t rx_char;
	logic rx_char_valid;
	uart_pkg::uart_char_t fifo_data;
	logic fifo_empty;
	logic fifo_pop;
	logic overflow;
	logic overflow_clear;
	uart_pkg::uart_char_t tx_char;
	logic tx_start;
	logic tx_busy;

	// Idle line is high
	synchronizer #(
		.RESET_STATE(1'b1)
	) rx_synchronizer (
		.clk(clk),
		.reset(reset),
		.data_in(uart_rx),
		.data_out(rx_sync)
	);

	// Shared by both directions
	baud_tick_gen baud_tick_gen (
		.clk(clk),
		.reset(reset),
		.divisor(divisor),
		.divisor_load(divisor_load),
		.tick(tick)
	);

	uart_receive uart_receive (
		.clk(clk),
		.reset(reset),
		.rx_sync(rx_sync),
		.tick(tick),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid)
	);

	uart_transmit uart_transmit (
		.clk(clk),
		.reset(reset),
		.tick(tick),
		.tx_start(tx_start),
		.tx_char(tx_char),
		.tx_busy(tx_busy),
		.uart_tx(uart_tx)
	);

	uart_rx_fifo uart_rx_fifo (
		.clk(clk),
		.reset(reset),
		.push(rx_char_valid),
		.push_data(rx_char),
		.pop(fifo_pop),
		.pop_data(fifo_data),
		.empty(fifo_empty),
		.overflow(overflow),
		.overflow_clear(overflow_clear)
	);

	uart_wb_regs uart_wb_regs (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.divisor(divisor),
		.divisor_load(divisor_load),
		.fifo_data(fifo_data),
		.fifo_empty(fifo_empty),
		.fifo_pop(fifo_pop),
		.overflow(overflow),
		.overflow_clear(overflow_clear),
		.tx_char(tx_char),
		.tx_start(tx_start),
		.tx_busy(tx_busy)
	);
endmodule

//--- hdl/uart_transmit.sv
/* UART transmitter FSM, sends 8N1 frames with 8 ticks per bit */

`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_transmit(
	input logic clk,
	input logic reset,
	input logic tick,
	input logic tx_start,
	input uart_pkg::uart_char_t tx_char,
	output logic tx_busy,
	output logic uart_tx
);
	localparam uart_pkg::uart_tick_count_t LAST_TICK = `UART_TICKS_PER_BIT - 1;
	localparam uart_pkg::uart_bit_count_t LAST_BIT = `UART_DATA_WIDTH - 1;

	uart_pkg::transmit_state_t state_ff;
	uart_pkg::transmit_state_t state_nxt;
	uart_pkg::uart_tick_count_t tick_count_ff;
	uart_pkg::uart_tick_count_t tick_count_nxt;
	uart_pkg::uart_bit_count_t bit_count_ff;
	uart_pkg::uart_bit_count_t bit_count_nxt;
	uart_pkg::uart_char_t shift_reg;
	logic tx_nxt;
	logic load_char;
	logic shift_char;
	logic bit_done;

	assign tx_busy = state_ff != uart_pkg::IDLE;
	// Last tick of the current bit
	assign bit_done = tick && tick_count_ff == LAST_TICK;

	always_comb
	begin
		state_nxt = state_ff;
		tick_count_nxt = tick_count_ff;
		bit_count_nxt = bit_count_ff;
		tx_nxt = uart_tx;
		load_char = 1'b0;
		shift_char = 1'b0;

		unique case (state_ff)
			uart_pkg::IDLE:
			begin
				if (tx_start)
				begin
					state_nxt = uart_pkg::START_BIT;
					load_char = 1'b1;
					tx_nxt = 1'b0;
				end
			end

			uart_pkg::START_BIT:
			begin
				if (bit_done)
				begin
					state_nxt = uart_pkg::DATA_BITS;
					bit_count_nxt = '0;
					tx_nxt = shift_reg[0];
				end
			end

			uart_pkg::DATA_BITS:
			begin
				if (bit_done)
				begin
					if (bit_count_ff == LAST_BIT)
					begin
						state_nxt = uart_pkg::STOP_BIT;
						tx_nxt = 1'b1;
					end
					else
					begin
						// Next bit comes from position 1 before the shift lands
						bit_count_nxt = bit_count_ff + 1'b1;
						shift_char = 1'b1;
						tx_nxt = shift_reg[1];
					end
				end
			end

			uart_pkg::STOP_BIT:
			begin
				if (bit_done)
					state_nxt = uart_pkg::IDLE;
			end
		endcase

		// Tick count wraps at each bit boundary, so it is zero again in IDLE
		if (tick && state_ff != uart_pkg::IDLE)
			tick_count_nxt = bit_done ? '0 : tick_count_ff + 1'b1;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			state_ff <= uart_pkg::IDLE;
			tick_count_ff <= '0;
			bit_count_ff <= '0;
			// Line idles high
			uart_tx <= 1'b1;
		end
		else
		begin
			state_ff <= state_nxt;
			tick_count_ff <= tick_count_nxt;
			bit_count_ff <= bit_count_nxt;
			uart_tx <= tx_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_char)
			shift_reg <= tx_char;
		else if (shift_char)
			shift_reg <= shift_reg >> 1;
	end
endmodule

//--- hdl/uart_wb_regs.sv
/* Wishbone classic slave for the UART data, status and divisor registers */

`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_wb_regs(
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input wb_pkg::wb_addr_t wb_adr,
	input wb_pkg::wb_data_t wb_dat_w,
	output wb_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	output uart_pkg::uart_divisor_t divisor,
	output logic divisor_load,
	input uart_pkg::uart_char_t fifo_data,
	input logic fifo_empty,
	output logic fifo_pop,
	input logic overflow,
	output logic overflow_clear,
	output uart_pkg::uart_char_t tx_char,
	output logic tx_start,
	input logic tx_busy
);
	logic is_data;
	logic is_status;
	logic is_divisor;
	logic pending;
	logic accept;
	wb_pkg::wb_data_t status_word;
	wb_pkg::wb_data_t read_data;

	assign is_data = wb_adr == wb_pkg::wb_addr_t'(`UART_REG_DATA);
	assign is_status = wb_adr == wb_pkg::wb_addr_t'(`UART_REG_STATUS);
	assign is_divisor = wb_adr == wb_pkg::wb_addr_t'(`UART_REG_DIVISOR);

	// Access seen but not yet acknowledged
	assign pending = wb_cyc && wb_stb && !wb_ack;
	// DATA writes stall while a frame is on the line
	assign accept = pending && !(wb_we && is_data && tx_busy);

	always_comb
	begin
		status_word = '0;
		status_word[`UART_STATUS_RX_AVAIL] = !fifo_empty;
		status_word[`UART_STATUS_TX_BUSY] = tx_busy;
		status_word[`UART_STATUS_RX_OVERFLOW] = overflow;
	end

	always_comb
	begin
		read_data = '0;
		// Empty FIFO reads back as zero
		if (is_data && !fifo_empty)
			read_data[`UART_DATA_WIDTH-1:0] = fifo_data;
		else if (is_status)
			read_data = status_word;
		else if (is_divisor)
			read_data[`UART_DIV_WIDTH-1:0] = divisor;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wb_ack <= 1'b0;
			tx_start <= 1'b0;
			fifo_pop <= 1'b0;
			overflow_clear <= 1'b0;
			divisor_load <= 1'b0;
			divisor <= uart_pkg::uart_divisor_t'(`UART_RESET_DIVISOR);
		end
		else
		begin
			// All strobes are one-cycle pulses that line up with ack
			wb_ack <= accept;
			tx_start <= accept && wb_we && is_data;
			fifo_pop <= accept && !wb_we && is_data && !fifo_empty;
			overflow_clear <= accept && !wb_we && is_status;
			// Load lands after the divisor register holds the new value
			divisor_load <= accept && wb_we && is_divisor;
			if (accept && wb_we && is_divisor)
				divisor <= wb_dat_w[`UART_DIV_WIDTH-1:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			wb_dat_r <= read_data;
		if (accept && wb_we && is_data)
			tx_char <= wb_dat_w[`UART_DATA_WIDTH-1:0];
	end
endmodule

//--- hdl/wb_pkg.sv
/* Wishbone bus-side types of the UART register block */

package wb_pkg;
	// Word address, selects one of the registers
	typedef logic [1:0] wb_addr_t;

	// Full bus word, no byte selects
	typedef logic [31:0] wb_data_t;
endpackage

//--- tb/uart_tb.sv
/* Testbench for the UART peripheral with random Wishbone and serial stimulus
   checked against a register and serial model */

`timescale 1ns/1ps
`include "uart_defines.svh"

module uart_tb;
	localparam int SEED = 32'h6be9_70b3;
	localparam int MIN_DIVISOR = 2;
	localparam int MAX_DIVISOR = 5;
	localparam int FRAME_TICKS = 80;
	localparam int TX_CHARS = 4;
	localparam int RX_CHARS = 6;
	localparam int FLOOD_CHARS = 10;
	// Frames of all tests plus two frames for the rx gaps
	localparam int TOTAL_FRAMES = TX_CHARS + RX_CHARS + 2 + FLOOD_CHARS + 2;
	localparam int BUS_ACCESSES = 120;
	localparam int CYCLE_LIMIT =
		2 * (TOTAL_FRAMES * FRAME_TICKS * (MAX_DIVISOR + 1) + BUS_ACCESSES * 4);

	localparam wb_pkg::wb_addr_t REG_DATA = wb_pkg::wb_addr_t'(`UART_REG_DATA);
	localparam wb_pkg::wb_addr_t REG_STATUS = wb_pkg::wb_addr_t'(`UART_REG_STATUS);
	localparam wb_pkg::wb_addr_t REG_DIVISOR = wb_pkg::wb_addr_t'(`UART_REG_DIVISOR);

	logic clk;
	logic reset;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_pkg::wb_addr_t wb_adr;
	wb_pkg::wb_data_t wb_dat_w;
	wb_pkg::wb_data_t wb_dat_r;
	logic wb_ack;
	logic uart_rx;
	logic uart_tx;

	// Model state
	uart_pkg::uart_char_t rx_model[$];
	uart_pkg::uart_char_t tx_expected[$];
	uart_pkg::uart_char_t tx_seen[$];
	logic model_overflow;
	int model_divisor;

	int checks;
	int errors;
	int cycle_count;

	uart_top DUT (
		.clk(clk),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.uart_rx(uart_rx),
		.uart_tx(uart_tx)
	);

	always #2 clk = ~clk;

	// Watchdog on the total run length
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic compare_value(input string name, input wb_pkg::wb_data_t expected,
		input wb_pkg::wb_data_t actual);
		checks++;
		assert (actual == expected)
		else
		begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// One classic cycle that starts and ends 1 ns after a rising edge
	task automatic bus_access(input logic we, input wb_pkg::wb_addr_t adr,
		input wb_pkg::wb_data_t wdata, output wb_pkg::wb_data_t rdata,
		output int wait_cycles);
		wait_cycles = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		// Ack sampled mid-cycle where it is stable
		@(negedge clk);
		wait_cycles++;
		while (!wb_ack)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		rdata = wb_dat_r;
		@(posedge clk);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	// Read ack follows stb by one clock with no stall
	task automatic bus_read(input wb_pkg::wb_addr_t adr, output wb_pkg::wb_data_t rdata);
		int wait_cycles;
		bus_access(1'b0, adr, '0, rdata, wait_cycles);
		compare_value("read ack latency", 32'd2, wait_cycles);
	endtask

	task automatic bus_write(input wb_pkg::wb_addr_t adr, input wb_pkg::wb_data_t wdata,
		output int wait_cycles);
		wb_pkg::wb_data_t unused;
		bus_access(1'b1, adr, wdata, unused, wait_cycles);
	endtask

	// Expected status comes from the model and the read clears the sticky overflow
	task automatic read_status(input string name, input logic busy);
		wb_pkg::wb_data_t expected;
		wb_pkg::wb_data_t actual;
		expected = '0;
		expected[`UART_STATUS_RX_AVAIL] = rx_model.size() != 0;
		expected[`UART_STATUS_TX_BUSY] = busy;
		expected[`UART_STATUS_RX_OVERFLOW] = model_overflow;
		bus_read(REG_STATUS, actual);
		compare_value(name, expected, actual);
		model_overflow = 1'b0;
	endtask

	// Expect the oldest model character or zero when nothing was received
	task automatic read_data(input string name);
		wb_pkg::wb_data_t expected;
		wb_pkg::wb_data_t actual;
		expected = '0;
		if (rx_model.size() != 0)
			expected = 32'(rx_model.pop_front());
		bus_read(REG_DATA, actual);
		compare_value(name, expected, actual);
	endtask

	task automatic wait_tx_idle();
		wb_pkg::wb_data_t status;
		bus_read(REG_STATUS, status);
		while (status[`UART_STATUS_TX_BUSY])
			bus_read(REG_STATUS, status);
	endtask

	task automatic compare_tx_frames(input string name);
		compare_value({name, " frame count"}, tx_expected.size(), tx_seen.size());
		while (tx_expected.size() != 0 && tx_seen.size() != 0)
			compare_value(name, 32'(tx_expected.pop_front()), 32'(tx_seen.pop_front()));
		tx_expected.delete();
		tx_seen.delete();
	endtask

	// Sends one 8N1 frame on uart_rx with 8 ticks of divisor+1 clocks per bit
	task automatic send_frame(input uart_pkg::uart_char_t ch);
		int bit_clocks;
		logic [9:0] frame;
		bit_clocks = 8 * (model_divisor + 1);
		frame = {1'b1, ch, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			uart_rx = frame[i];
			repeat (bit_clocks) @(posedge clk);
			#1;
		end
		// Character is in the FIFO before the stop bit ends
		if (rx_model.size() < `UART_RX_FIFO_DEPTH)
			rx_model.push_back(ch);
		else
			model_overflow = 1'b1;
	endtask

	// Serial monitor that samples uart_tx near the middle of each bit
	initial
	begin
		int bit_clocks;
		int half_clocks;
		logic [9:0] frame;
		@(negedge reset);
		forever
		begin
			@(negedge clk);
			if (uart_tx == 1'b0)
			begin
				bit_clocks = 8 * (model_divisor + 1);
				half_clocks = 4 * (model_divisor + 1);
				frame = '0;
				// Start bit may be short by up to one tick period
				for (int k = 0; k < 10; k++)
				begin
					repeat (k == 0 ? half_clocks : bit_clocks) @(negedge clk);
					frame[k] = uart_tx;
				end
				compare_value("tx start bit", 32'd0, 32'(frame[0]));
				compare_value("tx stop bit", 32'd1, 32'(frame[9]));
				tx_seen.push_back(frame[8:1]);
			end
		end
	end

	initial
	begin
		uart_pkg::uart_char_t ch;
		wb_pkg::wb_data_t rdata;
		int new_div;
		int wait_cycles;
		int min_wait;

		clk = 1'b0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		uart_rx = 1'b1;
		model_overflow = 1'b0;
		model_divisor = `UART_RESET_DIVISOR;
		checks = 0;
		errors = 0;
		cycle_count = 0;
		void'($urandom(SEED));

		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		// Let the synchronizer settle on the idle line
		repeat (3) @(posedge clk);
		#1;

		// Reset values and divisor read back
		compare_value("tx line after reset", 32'd1, 32'(uart_tx));
		read_status("status after reset", 1'b0);
		bus_read(REG_DIVISOR, rdata);
		compare_value("divisor after reset", `UART_RESET_DIVISOR, rdata);
		new_div = $urandom_range(MIN_DIVISOR, MAX_DIVISOR);
		bus_write(REG_DIVISOR, new_div, wait_cycles);
		model_divisor = new_div;
		bus_read(REG_DIVISOR, rdata);
		compare_value("divisor read back", new_div, rdata);

		// Transmit frames with busy shown while each one is on the line
		for (int i = 0; i < TX_CHARS; i++)
		begin
			ch = uart_pkg::uart_char_t'($urandom_range(0, 255));
			bus_write(REG_DATA, 32'(ch), wait_cycles);
			tx_expected.push_back(ch);
			read_status("status during frame", 1'b1);
			wait_tx_idle();
		end
		compare_tx_frames("tx data");

		// Receive with random gaps and reads in between
		for (int i = 0; i < RX_CHARS; i++)
		begin
			ch = uart_pkg::uart_char_t'($urandom_range(0, 255));
			send_frame(ch);
			repeat ($urandom_range(1, 24 * (model_divisor + 1))) @(posedge clk);
			#1;
			if ($urandom_range(0, 1) == 1)
				read_status("rx status", 1'b0);
			if ($urandom_range(0, 2) == 0)
				read_data("rx data");
		end
		while (rx_model.size() != 0)
			read_data("rx data drain");
		read_data("rx data when empty");
		read_status("rx status drained", 1'b0);

		// Flooding the FIFO keeps only the first eight
		for (int i = 0; i < FLOOD_CHARS; i++)
		begin
			ch = uart_pkg::uart_char_t'($urandom_range(0, 255));
			send_frame(ch);
		end
		read_status("overflow status", 1'b0);
		read_status("overflow cleared", 1'b0);
		while (rx_model.size() != 0)
			read_data("flood data");
		read_status("status after flood", 1'b0);

		// Second DATA write stalls until the first frame is out
		ch = uart_pkg::uart_char_t'($urandom_range(0, 255));
		bus_write(REG_DATA, 32'(ch), wait_cycles);
		tx_expected.push_back(ch);
		ch = uart_pkg::uart_char_t'($urandom_range(0, 255));
		bus_write(REG_DATA, 32'(ch), wait_cycles);
		// Whole first frame less at most one tick of start-bit phase
		min_wait = (FRAME_TICKS - 1) * (model_divisor + 1);
		checks++;
		assert (wait_cycles >= min_wait)
		else
		begin
			errors++;
			$display("[FAIL] back-pressure ack wait: expected at least %0d, actual %0d",
				min_wait, wait_cycles);
		end
		compare_value("frames done at second ack", 32'd1, tx_seen.size());
		tx_expected.push_back(ch);
		read_status("status during second frame", 1'b1);
		wait_tx_idle();
		compare_tx_frames("back-pressure tx");

		$display("Checks run: %0d, errors: %0d, cycles: %0d", checks, errors, cycle_count);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end
endmodule

//--- uart_top.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/wb_pkg.sv
hdl/synchronizer.sv
hdl/baud_tick_gen.sv
hdl/uart_receive.sv
hdl/uart_transmit.sv
hdl/uart_rx_fifo.sv
hdl/uart_wb_regs.sv
hdl/uart_top.sv
tb/uart_tb.sv
